// ==== project.f ====
src/mmio_pkg.sv
src/axil_mmio_port.sv
src/mmio_request_queue.sv
src/mmio_register_file.sv
src/mmio_subsystem.sv
bench/mmio_tb.sv

// ==== Bender.yml ====
package:
  name: mmio_subsystem

sources:
  - src/mmio_pkg.sv
  - src/axil_mmio_port.sv
  - src/mmio_request_queue.sv
  - src/mmio_register_file.sv
  - src/mmio_subsystem.sv
  - target: simulation
    files:
      - bench/mmio_tb.sv

// ==== bench/mmio_tb.sv ====
// testbench for the mmio peripheral block
// xorshift stimulus over AXI4-Lite, reference model of the registers
// in-order response checks, back-pressure test and a cycle watchdog

`timescale 1ns/1ps

module mmio_tb;
    import mmio_pkg::*;

    localparam int reset_cycles = 4;
    localparam int n_merge      = 16;
    localparam int n_product    = 8;
    localparam int n_pad        = 12;
    localparam int n_err        = 16;
    localparam int n_mixed      = 40;
    localparam int num_requests = 1 + 2 * n_merge + 3 * n_product + 4 + 2 * n_pad
                                  + 2 * n_err + 6 + n_mixed;
    localparam int cycle_limit  = 40 * num_requests + reset_cycles;

    // register index is address bits 4 to 2
    localparam logic [2:0] idx_status  = off_status[4:2];
    localparam logic [2:0] idx_mult_a  = off_mult_a[4:2];
    localparam logic [2:0] idx_mult_b  = off_mult_b[4:2];
    localparam logic [2:0] idx_product = off_product[4:2];
    localparam logic [2:0] idx_pad     = off_pad[4:2];

    logic                   vdp_clk;
    logic                   vdp_reset;
    logic                   awvalid;
    logic                   awready;
    logic [mmio_addr_w-1:0] awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [mmio_data_w-1:0] wdata;
    logic [mmio_strb_w-1:0] wstrb;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [mmio_addr_w-1:0] araddr;
    logic                   rvalid;
    logic                   rready;
    logic [mmio_data_w-1:0] rdata;
    logic [1:0]             rresp;
    logic [7:0]             pad_buttons;
    logic [1:0]             status_leds;

    // reference model with status reset to 01
    logic [1:0]  m_status = 2'b01;
    logic [15:0] m_a = '0;
    logic [15:0] m_b = '0;
    logic        m_latch = 1'b0;
    logic        m_clk = 1'b0;
    logic [7:0]  m_shift = '0;

    // expected responses as {write, err, data}
    logic [33:0] expected_q[$];
    logic [31:0] rng = 32'h7cc78d5a;
    logic        hold_resp = 1'b0;
    int          errors = 0;
    int          responses = 0;
    int          issued = 0;
    int          cycles = 0;

    mmio_subsystem dut_i (
        .vdp_clk     (vdp_clk),
        .vdp_reset   (vdp_reset),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .pad_buttons (pad_buttons),
        .status_leds (status_leds)
    );

    initial begin : clock_gen
        vdp_clk = 1'b0;
        forever #20 vdp_clk = ~vdp_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // a write edge still loads if the old latch was set
    task automatic update_pad(input logic latch, input logic clk);
        if (m_latch) begin
            m_shift = pad_buttons;
        end
        if (clk && !m_clk) begin
            m_shift = {1'b0, m_shift[7:1]};
        end
        if (latch) begin
            m_shift = pad_buttons;
        end
        m_latch = latch;
        m_clk   = clk;
    endtask

    task automatic predict_response(input logic wr, input logic [2:0] idx,
                                    input logic [31:0] data, input logic [3:0] strb);
        logic               err;
        logic [31:0]        rd;
        logic signed [31:0] prod;
        prod = $signed(m_a) * $signed(m_b);
        rd   = 32'h0;
        case (idx)
            idx_status, idx_mult_a, idx_mult_b, idx_pad: err = 1'b0;
            idx_product: err = wr;
            default:     err = 1'b1;
        endcase
        if (wr && !err) begin
            case (idx)
                idx_status: if (strb[0]) m_status = data[1:0];
                idx_mult_a: begin
                    if (strb[0]) m_a[7:0] = data[7:0];
                    if (strb[1]) m_a[15:8] = data[15:8];
                end
                idx_mult_b: begin
                    if (strb[0]) m_b[7:0] = data[7:0];
                    if (strb[1]) m_b[15:8] = data[15:8];
                end
                default: if (strb[0]) update_pad(data[0], data[1]);
            endcase
        end else if (!err) begin
            case (idx)
                idx_status:  rd = {30'h0, m_status};
                idx_mult_a:  rd = {16'h0, m_a};
                idx_mult_b:  rd = {16'h0, m_b};
                idx_product: rd = prod;
                default:     rd = {31'h0, m_shift[0]};
            endcase
        end
        expected_q.push_back({wr, err, rd});
    endtask

    task automatic check_response(input logic is_write, input logic [1:0] resp,
                                  input logic [31:0] data);
        logic [33:0] exp;
        if (expected_q.size() == 0) begin
            $display("response at %0t with no request outstanding", $time);
            errors++;
        end else begin
            exp = expected_q.pop_front();
            responses++;
            if (exp[33] != is_write) begin
                $display("response at %0t came back on the wrong channel", $time);
                errors++;
            end else if (is_write) begin
                check_value("bresp", exp[32] ? axi_resp_slverr : axi_resp_okay, resp);
            end else begin
                check_value("rresp", exp[32] ? axi_resp_slverr : axi_resp_okay, resp);
                check_value("rdata", exp[31:0], data);
            end
        end
    endtask

    task automatic start_request(input logic wr, input logic [2:0] idx,
                                 input logic [31:0] data, input logic [3:0] strb);
        predict_response(wr, idx, data, strb);
        issued++;
        if (wr) begin
            awaddr  = {3'b000, idx, 2'b00};
            wdata   = data;
            wstrb   = strb;
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end else begin
            araddr  = {3'b000, idx, 2'b00};
            arvalid = 1'b1;
        end
    endtask

    // valids stay up until a ready is seen mid-cycle
    task automatic accept_request();
        @(negedge vdp_clk);
        while (!(awready || arready)) begin
            @(negedge vdp_clk);
        end
        if (awvalid) begin
            check_value("wready", 32'h1, wready);
        end
        @(posedge vdp_clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
    endtask

    task automatic send_request(input logic wr, input logic [2:0] idx,
                                input logic [31:0] data, input logic [3:0] strb);
        start_request(wr, idx, data, strb);
        accept_request();
    endtask

    task automatic drain();
        while (expected_q.size() != 0) begin
            @(posedge vdp_clk);
            #2;
        end
    endtask

    task automatic set_buttons(input logic [7:0] value);
        pad_buttons = value;
        if (m_latch) begin
            m_shift = value;
        end
    endtask

    // response side with random stalls on B and R
    initial begin : response_monitor
        logic        b_next;
        logic        r_next;
        logic [31:0] r;
        forever begin
            @(negedge vdp_clk);
            if (bvalid && bready) begin
                check_response(1'b1, bresp, 32'h0);
            end
            if (rvalid && rready) begin
                check_response(1'b0, rresp, rdata);
            end
            r      = next_random();
            b_next = !hold_resp && (r[1:0] != 2'b00);
            r_next = !hold_resp && (r[3:2] != 2'b00);
            @(posedge vdp_clk);
            #2;
            bready = b_next;
            rready = r_next;
        end
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge vdp_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("%0d requests, %0d responses, %0d errors", issued, responses, errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        int          i;
        logic [31:0] r;
        logic [2:0]  idx;
        vdp_reset   = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        pad_buttons = '0;
        repeat (reset_cycles) @(posedge vdp_clk);
        #2;
        vdp_reset = 1'b0;

        // state after reset
        check_value("status_leds", 32'h1, status_leds);
        repeat (3) begin
            @(negedge vdp_clk);
            check_value("bvalid", 32'h0, bvalid);
            check_value("rvalid", 32'h0, rvalid);
        end
        @(posedge vdp_clk);
        #2;
        send_request(1'b0, idx_status, 32'h0, 4'h0);
        drain();

        // strobed writes and readback
        for (i = 0; i < n_merge; i++) begin
            r   = next_random();
            idx = (r[5:4] == 2'd0) ? idx_status : ((r[5:4] == 2'd1) ? idx_mult_a : idx_mult_b);
            send_request(1'b1, idx, next_random(), r[3:0]);
            send_request(1'b0, idx, 32'h0, 4'h0);
            drain();
            check_value("status_leds", m_status, status_leds);
        end

        // signed product
        for (i = 0; i < n_product; i++) begin
            send_request(1'b1, idx_mult_a, next_random(), 4'hf);
            send_request(1'b1, idx_mult_b, next_random(), 4'hf);
            send_request(1'b0, idx_product, 32'h0, 4'h0);
        end

        // gamepad latch then shifting on clock writes
        drain();
        r = next_random();
        set_buttons(r[7:0]);
        send_request(1'b1, idx_pad, 32'h1, 4'h1);
        send_request(1'b0, idx_pad, 32'h0, 4'h0);
        drain();
        r = next_random();
        set_buttons(r[7:0]);
        send_request(1'b0, idx_pad, 32'h0, 4'h0);
        send_request(1'b1, idx_pad, 32'h0, 4'h1);
        drain();
        r = next_random();
        set_buttons(r[7:0]);
        for (i = 0; i < n_pad; i++) begin
            r = next_random();
            send_request(1'b1, idx_pad, {30'h0, i[0], 1'b0}, {3'b000, r[0] | r[1]});
            send_request(1'b0, idx_pad, 32'h0, 4'h0);
        end

        // error responses each followed by a readback of a mapped register
        for (i = 0; i < n_err; i++) begin
            r = next_random();
            if (r[1:0] == 2'b00) begin
                send_request(1'b1, idx_product, next_random(), 4'hf);
            end else begin
                idx = r[2] ? 3'd7 : (r[3] ? 3'd6 : 3'd5);
                send_request(r[4], idx, next_random(), 4'hf);
            end
            send_request(1'b0, r[10:8] % 3'd5, 32'h0, 4'h0);
        end

        // five requests fit before the sixth has to wait
        drain();
        hold_resp = 1'b1;
        repeat (5) begin
            r = next_random();
            send_request(r[3], r[2:0], next_random(), r[7:4]);
        end
        r = next_random();
        start_request(r[3], r[2:0], next_random(), r[7:4]);
        repeat (10) begin
            @(negedge vdp_clk);
            check_value("awready", 32'h0, awready);
            check_value("wready", 32'h0, wready);
            check_value("arready", 32'h0, arready);
        end
        @(posedge vdp_clk);
        #2;
        hold_resp = 1'b0;
        accept_request();

        // mixed traffic with several requests outstanding
        for (i = 0; i < n_mixed; i++) begin
            r = next_random();
            send_request(r[3], r[2:0], next_random(), r[7:4]);
        end
        drain();
        check_value("status_leds", m_status, status_leds);

        $display("%0d requests, %0d responses, %0d errors", issued, responses, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== src/mmio_subsystem.sv ====
// top level of the mmio peripheral block
// AXI4-Lite port, request queue and register file

`timescale 1ns/1ps

module mmio_subsystem (
    input  logic                             vdp_clk,
    input  logic                             vdp_reset,

    input  logic                             awvalid,
    output logic                             awready,
    input  logic [mmio_pkg::mmio_addr_w-1:0] awaddr,
    input  logic                             wvalid,
    output logic                             wready,
    input  logic [mmio_pkg::mmio_data_w-1:0] wdata,
    input  logic [mmio_pkg::mmio_strb_w-1:0] wstrb,
    output logic                             bvalid,
    input  logic                             bready,
    output logic [1:0]                       bresp,

    input  logic                             arvalid,
    output logic                             arready,
    input  logic [mmio_pkg::mmio_addr_w-1:0] araddr,
    output logic                             rvalid,
    input  logic                             rready,
    output logic [mmio_pkg::mmio_data_w-1:0] rdata,
    output logic [1:0]                       rresp,

    input  logic [7:0]                       pad_buttons,
    output logic [1:0]                       status_leds
);
    import mmio_pkg::*;

    logic                   push_valid;
    logic [mmio_req_w-1:0]  push_data;
    logic                   queue_full;
    logic                   pop_valid;
    logic [mmio_req_w-1:0]  pop_data;
    logic                   pop_ready;
    logic                   resp_valid;
    logic                   resp_write;
    logic                   resp_err;
    logic [mmio_data_w-1:0] resp_data;
    logic                   resp_ready;

    axil_mmio_port port_i (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .push_valid (push_valid),
        .push_data  (push_data),
        .queue_full (queue_full),
        .resp_valid (resp_valid),
        .resp_write (resp_write),
        .resp_err   (resp_err),
        .resp_data  (resp_data),
        .resp_ready (resp_ready)
    );

    mmio_request_queue queue_i (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .push_valid (push_valid),
        .push_data  (push_data),
        .full       (queue_full),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .pop_ready  (pop_ready)
    );

    mmio_register_file regfile_i (
        .vdp_clk     (vdp_clk),
        .vdp_reset   (vdp_reset),
        .pop_valid   (pop_valid),
        .pop_data    (pop_data),
        .pop_ready   (pop_ready),
        .resp_valid  (resp_valid),
        .resp_write  (resp_write),
        .resp_err    (resp_err),
        .resp_data   (resp_data),
        .resp_ready  (resp_ready),
        .pad_buttons (pad_buttons),
        .status_leds (status_leds)
    );

endmodule

// ==== src/mmio_register_file.sv ====
// mmio register file, consumer side of the request queue
// status/LED register, signed 16x16 multiplier, gamepad shift register
// idle/exec/resp FSM producing one response per request

`timescale 1ns/1ps

module mmio_register_file (
    input  logic                             vdp_clk,
    input  logic                             vdp_reset,
    input  logic                             pop_valid,
    input  logic [mmio_pkg::mmio_req_w-1:0]  pop_data,
    output logic                             pop_ready,
    output logic                             resp_valid,
    output logic                             resp_write,
    output logic                             resp_err,
    output logic [mmio_pkg::mmio_data_w-1:0] resp_data,
    input  logic                             resp_ready,
    input  logic [7:0]                       pad_buttons,
    output logic [1:0]                       status_leds
);
    import mmio_pkg::*;

    regfile_state_e           state;
    logic [mmio_req_w-1:0]    req_q;
    logic                     req_write;
    logic [mmio_addr_w-1:0]   req_addr;
    logic [mmio_data_w-1:0]   req_data;
    logic [mmio_strb_w-1:0]   req_strb;
    mmio_reg_e                req_reg;
    logic                     wr_en;
    logic                     req_err;
    logic [mmio_data_w-1:0]   read_value;

    logic [1:0]               status;
    logic signed [15:0]       mult_a;
    logic signed [15:0]       mult_b;
    logic signed [31:0]       product;
    logic                     pad_latch;
    logic                     pad_clk;
    logic                     pad_clk_q;
    logic [7:0]               pad_shift;

    function automatic mmio_reg_e decode_reg(input logic [mmio_addr_w-1:0] addr);
        mmio_reg_e sel;
        case (addr[4:2])
            off_status[4:2]:  sel = reg_status;
            off_mult_a[4:2]:  sel = reg_mult_a;
            off_mult_b[4:2]:  sel = reg_mult_b;
            off_product[4:2]: sel = reg_product;
            off_pad[4:2]:     sel = reg_pad;
            default:          sel = reg_unmapped;
        endcase
        return sel;
    endfunction

    // byte-lane merge for the 16-bit operands
    function automatic logic [15:0] merge16(input logic [15:0] old_value,
                                            input logic [15:0] new_value,
                                            input logic [1:0]  strb);
        logic [15:0] merged;
        merged[7:0]  = strb[0] ? new_value[7:0]  : old_value[7:0];
        merged[15:8] = strb[1] ? new_value[15:8] : old_value[15:8];
        return merged;
    endfunction

    assign {req_write, req_addr, req_data, req_strb} = req_q;
    assign req_reg = decode_reg(req_addr);

    assign pop_ready   = (state == st_idle);
    assign resp_valid  = (state == st_resp);
    assign status_leds = status;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (pop_valid) state <= st_exec;
                st_exec: state <= st_resp;
                st_resp: if (resp_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (pop_valid && pop_ready) begin
            req_q <= pop_data;
        end
    end

    assign wr_en   = (state == st_exec) && req_write;
    // product is read-only
    assign req_err = (req_reg == reg_unmapped) || (req_write && req_reg == reg_product);

    always_comb begin
        read_value = '0;
        if (!req_write && !req_err) begin
            case (req_reg)
                reg_status:  read_value = {30'b0, status};
                reg_mult_a:  read_value = {16'b0, mult_a};
                reg_mult_b:  read_value = {16'b0, mult_b};
                reg_product: read_value = product;
                reg_pad:     read_value = {31'b0, pad_shift[0]};
                default:     read_value = '0;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (state == st_exec) begin
            resp_write <= req_write;
            resp_err   <= req_err;
            resp_data  <= read_value;
        end
    end

    // status and pad control use lane 0
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status    <= status_reset_value;
            mult_a    <= '0;
            mult_b    <= '0;
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
        end else if (wr_en) begin
            case (req_reg)
                reg_status: if (req_strb[0]) status <= req_data[1:0];
                reg_mult_a: mult_a <= merge16(mult_a, req_data[15:0], req_strb[1:0]);
                reg_mult_b: mult_b <= merge16(mult_b, req_data[15:0], req_strb[1:0]);
                reg_pad: begin
                    if (req_strb[0]) begin
                        pad_latch <= req_data[0];
                        pad_clk   <= req_data[1];
                    end
                end
                default: ;
            endcase
        end
    end

    // free-running multiply, settled long before the next exec
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            product <= '0;
        end else begin
            product <= mult_a * mult_b;
        end
    end

    // shift on a rising pad clock, otherwise load while latched
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_shift <= '0;
            pad_clk_q <= 1'b0;
        end else begin
            pad_clk_q <= pad_clk;
            if (pad_clk && !pad_clk_q) begin
                pad_shift <= {1'b0, pad_shift[7:1]};
            end else if (pad_latch) begin
                pad_shift <= pad_buttons;
            end
        end
    end

endmodule

// ==== src/mmio_request_queue.sv ====
// request FIFO between the AXI port and the register file
// circular buffer with read/write pointers and an occupancy count

`timescale 1ns/1ps

module mmio_request_queue (
    input  logic                             vdp_clk,
    input  logic                             vdp_reset,
    input  logic                             push_valid,
    input  logic [mmio_pkg::mmio_req_w-1:0]  push_data,
    output logic                             full,
    output logic                             pop_valid,
    output logic [mmio_pkg::mmio_req_w-1:0]  pop_data,
    input  logic                             pop_ready
);
    import mmio_pkg::*;

    localparam int ptr_w = $clog2(mmio_queue_depth);
    localparam int cnt_w = $clog2(mmio_queue_depth + 1);

    logic [mmio_req_w-1:0] mem [mmio_queue_depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;
    logic                  do_push;
    logic                  do_pop;

    assign full      = (count == cnt_w'(mmio_queue_depth));
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];

    assign do_pop  = pop_valid && pop_ready;
    // a pop frees the slot in the same cycle
    assign do_push = push_valid && (!full || do_pop);

    always_ff @(posedge vdp_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(mmio_queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(mmio_queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== src/axil_mmio_port.sv ====
// AXI4-Lite slave front end of the mmio block
// write-first arbitration of AW/W against AR into a registered queue push
// in-order responses steered onto B or R

`timescale 1ns/1ps

module axil_mmio_port (
    input  logic                               vdp_clk,
    input  logic                               vdp_reset,

    input  logic                               awvalid,
    output logic                               awready,
    input  logic [mmio_pkg::mmio_addr_w-1:0]   awaddr,
    input  logic                               wvalid,
    output logic                               wready,
    input  logic [mmio_pkg::mmio_data_w-1:0]   wdata,
    input  logic [mmio_pkg::mmio_strb_w-1:0]   wstrb,
    output logic                               bvalid,
    input  logic                               bready,
    output logic [1:0]                         bresp,

    input  logic                               arvalid,
    output logic                               arready,
    input  logic [mmio_pkg::mmio_addr_w-1:0]   araddr,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [mmio_pkg::mmio_data_w-1:0]   rdata,
    output logic [1:0]                         rresp,

    output logic                               push_valid,
    output logic [mmio_pkg::mmio_req_w-1:0]    push_data,
    input  logic                               queue_full,

    input  logic                               resp_valid,
    input  logic                               resp_write,
    input  logic                               resp_err,
    input  logic [mmio_pkg::mmio_data_w-1:0]   resp_data,
    output logic                               resp_ready
);
    import mmio_pkg::*;

    logic write_go;
    logic read_go;

    // one accept per push slot, so full is never stale when the push lands
    always_comb begin
        write_go = awvalid && wvalid && !queue_full && !push_valid;
        read_go  = arvalid && !(awvalid && wvalid) && !queue_full && !push_valid;
    end

    assign awready = write_go;
    assign wready  = write_go;
    assign arready = read_go;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= write_go || read_go;
        end
    end

    // reads carry no data and no strobes
    always_ff @(posedge vdp_clk) begin
        if (write_go) begin
            push_data <= {1'b1, awaddr, wdata, wstrb};
        end else if (read_go) begin
            push_data <= {1'b0, araddr, {mmio_data_w{1'b0}}, {mmio_strb_w{1'b0}}};
        end
    end

    // response steering
    assign bvalid = resp_valid && resp_write;
    assign rvalid = resp_valid && !resp_write;
    assign bresp  = resp_err ? axi_resp_slverr : axi_resp_okay;
    assign rresp  = resp_err ? axi_resp_slverr : axi_resp_okay;
    assign rdata  = resp_data;

    assign resp_ready = resp_write ? bready : rready;

endmodule

// ==== src/mmio_pkg.sv ====
// shared definitions for the mmio peripheral block
// bus widths, queue depth, register offsets, reset value
// enums for register select and consumer state

package mmio_pkg;

    // bus geometry
    localparam int mmio_addr_w = 8;
    localparam int mmio_data_w = 32;
    localparam int mmio_strb_w = mmio_data_w / 8;

    localparam int mmio_queue_depth = 4;

    // queue entry is {write, addr, data, strb}
    localparam int mmio_req_w = 1 + mmio_addr_w + mmio_data_w + mmio_strb_w;

    localparam logic [1:0] status_reset_value = 2'b01;

    // byte offsets of the registers
    localparam logic [mmio_addr_w-1:0] off_status  = 8'h00;
    localparam logic [mmio_addr_w-1:0] off_mult_a  = 8'h04;
    localparam logic [mmio_addr_w-1:0] off_mult_b  = 8'h08;
    localparam logic [mmio_addr_w-1:0] off_product = 8'h0c;
    localparam logic [mmio_addr_w-1:0] off_pad     = 8'h10;

    // AXI response codes
    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // target register, numbered as address bits 4 to 2
    typedef enum logic [2:0] {
        reg_status   = 3'd0,
        reg_mult_a   = 3'd1,
        reg_mult_b   = 3'd2,
        reg_product  = 3'd3,
        reg_pad      = 3'd4,
        reg_unmapped = 3'd7
    } mmio_reg_e;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_resp
    } regfile_state_e;

endpackage
